// File: Makefile
TOOL     = verilator
TOP      = dcEntropyEncoderTb
FILELIST = verilog.f
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal --top-module $(TOP)
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) -f $(FILELIST) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@grep -q "Everything OK" $(LOG) || (echo "TEST FAILED"; exit 1)
	@echo "TEST PASSED"

clean:
	rm -rf obj_dir $(LOG)

// File: design/codeMerger.sv
`default_nettype none

module codeMerger
  import jpegStreamPkg::*, huffmanCodePkg::*;
(
  input logic clk,
  input logic rst_n,
  input dcSymbol_t symbol,
  input huffCode_t code,
  output alignedCode_t merged
);

  dcSymbol_t symbolDly;
  logic [VLI_W-1:0] vliMask;
  logic [MAX_CODE_W-1:0] bits;
  logic [CODE_LEN_W-1:0] length;
  logic [WORD_W-1:0] aligned;

  // lines up with the registered table entry.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      symbolDly <= '0;
    end else begin
      symbolDly <= symbol;
    end
  end

  // ========================================
  // merge and left-align.
  always_comb begin
    vliMask = ~({VLI_W{1'b1}} << symbolDly.category);
    bits = (MAX_CODE_W'(code.code) << symbolDly.category)
      | MAX_CODE_W'(symbolDly.vli & vliMask);
    length = CODE_LEN_W'(code.length) + CODE_LEN_W'(symbolDly.category);
    // move the low length bits up to the msb end.
    aligned = {bits, {(WORD_W - MAX_CODE_W){1'b0}}}
      << (CODE_LEN_W'(MAX_CODE_W) - length);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      merged <= '0;
    end else begin
      merged.valid <= symbolDly.valid;
      merged.done <= symbolDly.done;
      merged.length <= length;
      merged.bits <= aligned;
    end
  end

endmodule

`default_nettype wire

// File: design/dcCodeTable.sv
`default_nettype none

module dcCodeTable
  import jpegStreamPkg::*, huffmanCodePkg::*;
#(
  parameter component_t codeTable = luminance
) (
  input logic clk,
  input dcSymbol_t symbol,
  output huffCode_t code
);

  // annex K DC tables, indexed by category.
  localparam huffCode_t LUMA_TABLE [MAX_CATEGORY+1] = '{
    '{4'd2, 11'b00000000000},
    '{4'd3, 11'b00000000010},
    '{4'd3, 11'b00000000011},
    '{4'd3, 11'b00000000100},
    '{4'd3, 11'b00000000101},
    '{4'd3, 11'b00000000110},
    '{4'd4, 11'b00000001110},
    '{4'd5, 11'b00000011110},
    '{4'd6, 11'b00000111110},
    '{4'd7, 11'b00001111110},
    '{4'd8, 11'b00011111110},
    '{4'd9, 11'b00111111110}
  };

  localparam huffCode_t CHROMA_TABLE [MAX_CATEGORY+1] = '{
    '{4'd2, 11'b00000000000},
    '{4'd2, 11'b00000000001},
    '{4'd2, 11'b00000000010},
    '{4'd3, 11'b00000000110},
    '{4'd4, 11'b00000001110},
    '{4'd5, 11'b00000011110},
    '{4'd6, 11'b00000111110},
    '{4'd7, 11'b00001111110},
    '{4'd8, 11'b00011111110},
    '{4'd9, 11'b00111111110},
    '{4'd10, 11'b01111111110},
    '{4'd11, 11'b11111111110}
  };

  huffCode_t entry;

  // categories above the table give an empty entry.
  always_comb begin
    entry = '0;
    if (symbol.category <= MAX_CATEGORY) begin
      if (codeTable == luminance) begin
        entry = LUMA_TABLE[symbol.category];
      end else begin
        entry = CHROMA_TABLE[symbol.category];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (symbol.valid) begin
      code <= entry;
    end
  end

endmodule

`default_nettype wire

// File: design/dcEntropyEncoder.sv
`default_nettype none

module dcEntropyEncoder
  import jpegStreamPkg::*, huffmanCodePkg::*;
#(
  parameter component_t codeTable = luminance
) (
  input logic clk,
  input logic rst_n,
  input dcSymbol_t symbol,
  output packedWord_t packedWord
);

  huffCode_t code;
  alignedCode_t merged;

  dcCodeTable #(
    .codeTable(codeTable)
  ) dcCodeTable_i (
    .clk(clk),
    .symbol(symbol),
    .code(code)
  );

  codeMerger codeMerger_i (
    .clk(clk),
    .rst_n(rst_n),
    .symbol(symbol),
    .code(code),
    .merged(merged)
  );

  wordPacker wordPacker_i (
    .clk(clk),
    .rst_n(rst_n),
    .merged(merged),
    .packedWord(packedWord)
  );

endmodule

`default_nettype wire

// File: design/huffmanCodePkg.sv
`default_nettype none

package huffmanCodePkg;

  // ========================================
  // DC table geometry.
  localparam int MAX_CATEGORY = 11;
  localparam int HUFF_CODE_W = 11;
  localparam int HUFF_LEN_W = 4;

  // code is right-aligned, length counts its valid bits.
  typedef struct packed {
    logic [HUFF_LEN_W-1:0] length;
    logic [HUFF_CODE_W-1:0] code;
  } huffCode_t;

  typedef enum logic {
    luminance,
    chrominance
  } component_t;

endpackage

`default_nettype wire

// File: design/jpegStreamPkg.sv
`default_nettype none

package jpegStreamPkg;

  // ========================================
  // stream widths.
  localparam int WORD_W = 32;
  localparam int MAX_CODE_W = 22;
  localparam int CATEGORY_W = 4;
  localparam int VLI_W = 11;
  localparam int CODE_LEN_W = $clog2(MAX_CODE_W + 1);
  localparam int SIZE_W = $clog2(WORD_W + 1);
  localparam int FILL_W = $clog2(WORD_W);

  // ========================================
  // one DC symbol per valid cycle.
  typedef struct packed {
    logic valid;
    logic done;
    logic [CATEGORY_W-1:0] category;
    logic [VLI_W-1:0] vli;
  } dcSymbol_t;

  // huffman code plus amplitude, msb at bit WORD_W-1.
  typedef struct packed {
    logic valid;
    logic done;
    logic [CODE_LEN_W-1:0] length;
    logic [WORD_W-1:0] bits;
  } alignedCode_t;

  typedef struct packed {
    logic valid;
    logic done;
    logic [SIZE_W-1:0] size;
    logic [WORD_W-1:0] word;
  } packedWord_t;

  typedef enum logic {
    normal,
    spill
  } packState_t;

endpackage

`default_nettype wire

// File: design/wordPacker.sv
`default_nettype none

module wordPacker
  import jpegStreamPkg::*;
(
  input logic clk,
  input logic rst_n,
  input alignedCode_t merged,
  output packedWord_t packedWord
);

  typedef struct packed {
    logic valid;
    logic done;
    logic overflow;
    logic [SIZE_W-1:0] size;
  } packStage_t;

  logic [FILL_W-1:0] fill;
  logic [SIZE_W-1:0] sum;
  logic [SIZE_W-1:0] wrapped;
  logic [SIZE_W-1:0] finalSize;
  logic overflow;
  packStage_t stage;
  packStage_t stageNext;
  logic [WORD_W-1:0] up;
  logic [WORD_W-1:0] low;

  packState_t state;
  packState_t stateNext;
  logic [WORD_W-1:0] partial;
  logic [WORD_W-1:0] partialNext;
  logic [WORD_W-1:0] word;
  logic [SIZE_W-1:0] spillSize;
  logic [SIZE_W-1:0] spillSizeNext;
  packedWord_t outNext;

  // ========================================
  // fill count and split.
  always_comb begin
    sum = SIZE_W'(fill) + SIZE_W'(merged.length);
    overflow = sum >= SIZE_W'(WORD_W);
    wrapped = overflow ? sum - SIZE_W'(WORD_W) : sum;
    finalSize = (wrapped == '0) ? SIZE_W'(WORD_W) : wrapped;
    stageNext.valid = merged.valid;
    stageNext.done = merged.done;
    // exact fill on done closes in one word.
    stageNext.overflow = overflow && !(merged.done && wrapped == '0);
    stageNext.size = finalSize;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill <= '0;
      stage <= '0;
    end else begin
      stage <= stageNext;
      if (merged.valid) begin
        fill <= merged.done ? '0 : FILL_W'(wrapped);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (merged.valid) begin
      {up, low} <= {merged.bits, {WORD_W{1'b0}}} >> fill;
    end
  end

  // ========================================
  // word assembly.
  always_comb begin
    stateNext = state;
    partialNext = partial;
    spillSizeNext = spillSize;
    word = partial | up;
    outNext = '0;
    case (state)
      normal: begin
        if (stage.valid) begin
          partialNext = word;
          if (stage.done || stage.overflow) begin
            outNext.valid = 1'b1;
            outNext.size = SIZE_W'(WORD_W);
            outNext.word = word;
            partialNext = low;
          end
          if (stage.done && stage.overflow) begin
            stateNext = spill;
            spillSizeNext = stage.size;
          end else if (stage.done) begin
            outNext.done = 1'b1;
            outNext.size = stage.size;
          end
        end
      end
      spill: begin
        outNext.valid = 1'b1;
        outNext.done = 1'b1;
        outNext.size = spillSize;
        outNext.word = partial;
        partialNext = '0;
        stateNext = normal;
        // a new block starts at fill zero.
        if (stage.valid) begin
          partialNext = up;
          if (stage.done) begin
            stateNext = spill;
            spillSizeNext = stage.size;
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= normal;
      partial <= '0;
      packedWord <= '0;
    end else begin
      state <= stateNext;
      partial <= partialNext;
      packedWord <= outNext;
    end
  end

  always_ff @(posedge clk) begin
    spillSize <= spillSizeNext;
  end

endmodule

`default_nettype wire

// File: verification/dcEntropyEncoderTb.sv
`default_nettype none

module dcEntropyEncoderTb
  import jpegStreamPkg::*, huffmanCodePkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // annex K luminance DC codes, right-aligned.
  localparam int LUMA_LEN [MAX_CATEGORY+1] = '{2, 3, 3, 3, 3, 3, 4, 5, 6, 7, 8, 9};
  localparam int LUMA_CODE [MAX_CATEGORY+1] = '{0, 2, 3, 4, 5, 6, 14, 30, 62, 126, 254, 510};
  localparam int RANDOM_BLOCKS = 60;

  logic clk;
  logic rst_n;
  dcSymbol_t symbol;
  packedWord_t packedWord;

  dcSymbol_t stimQ [$];
  dcSymbol_t blockQ [$];
  packedWord_t expQ [$];
  string nameQ [$];
  logic [15:0] lfsr = 16'd54;
  int cycleLimit;
  int cycles;
  bit started;
  bit passed;
  bit failed;

  dcEntropyEncoder #(
    .codeTable(luminance)
  ) dcEntropyEncoder_i (
    .clk(clk),
    .rst_n(rst_n),
    .symbol(symbol),
    .packedWord(packedWord)
  );

  bind wordPacker dcEntropyEncoderAsserts asserts_i (
    .clk(clk),
    .rst_n(rst_n),
    .packedWord(packedWord)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ========================================
  // stimulus and reference model.

  // fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1.
  function automatic int randBits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      r = (r << 1) | int'(lfsr[0]);
    end
    return r;
  endfunction

  function automatic void addIdle(input int n);
    for (int i = 0; i < n; i++) begin
      stimQ.push_back('0);
    end
  endfunction

  function automatic void addSymbol(input int cat, input int vli, input bit done, input int gap);
    dcSymbol_t s;
    s.valid = 1'b1;
    s.done = done;
    s.category = CATEGORY_W'(cat);
    s.vli = VLI_W'(vli);
    blockQ.push_back(s);
    stimQ.push_back(s);
    addIdle(gap);
  endfunction

  // one msb-first bit string per block, cut into words.
  function automatic void expectBlock(input string name);
    bit bitQ [$];
    packedWord_t w;
    int cat;
    int code;
    int n;
    foreach (blockQ[s]) begin
      cat = int'(blockQ[s].category);
      code = LUMA_CODE[cat];
      for (int i = LUMA_LEN[cat] - 1; i >= 0; i--) bitQ.push_back(code[i]);
      for (int i = cat - 1; i >= 0; i--) bitQ.push_back(blockQ[s].vli[i]);
    end
    while (bitQ.size() > 0) begin
      n = (bitQ.size() < WORD_W) ? bitQ.size() : WORD_W;
      w = '0;
      w.valid = 1'b1;
      w.size = SIZE_W'(n);
      for (int i = 0; i < n; i++) begin
        w.word[WORD_W-1-i] = bitQ.pop_front();
      end
      w.done = bitQ.size() == 0;
      expQ.push_back(w);
      nameQ.push_back(name);
    end
    blockQ.delete();
  endfunction

  function automatic void buildStimulus();
    int len;
    int cat;
    int vli;
    int gap;
    addIdle(4);
    addSymbol(0, 'h5a5, 1'b1, 2);
    expectBlock("single short");
    // 20 + 10 + 2 bits.
    addSymbol(11, 'h7ff, 1'b0, 0);
    addSymbol(6, 'h02a, 1'b0, 1);
    addSymbol(0, 'h000, 1'b1, 2);
    expectBlock("exact fill");
    addSymbol(11, 'h3c5, 1'b0, 0);
    addSymbol(11, 'h5f0, 1'b1, 0);
    expectBlock("overflow final");
    addSymbol(3, 'h7f5, 1'b1, 3);
    expectBlock("back to back");
    for (int b = 0; b < RANDOM_BLOCKS; b++) begin
      len = 1 + randBits(3);
      for (int k = 0; k < len; k++) begin
        cat = randBits(4) % (MAX_CATEGORY + 1);
        vli = randBits(VLI_W);
        gap = randBits(2);
        addSymbol(cat, vli, k == len - 1, gap);
      end
      expectBlock($sformatf("random block %0d", b));
    end
    cycleLimit = 2 * stimQ.size() + 20;
  endfunction

  // ========================================
  // checking.

  task automatic failRun(input string why);
    $display("%s", why);
    failed = 1'b1;
    $display("Something failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  function automatic string formatWord(input packedWord_t w);
    return $sformatf("v=%b d=%b size=%0d word=%h", w.valid, w.done, w.size, w.word);
  endfunction

  task automatic compareWord(input string name, input packedWord_t exp, input packedWord_t act);
    if (act !== exp) begin
      failRun($sformatf("Mismatch %s expected %s actual %s",
        name, formatWord(exp), formatWord(act)));
    end
  endtask

  initial begin
    symbol = '0;
    rst_n = 1'b0;
    buildStimulus();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    while (stimQ.size() > 0) begin
      @(posedge clk);
      symbol <= stimQ[0];
      if (stimQ[0].valid) started = 1'b1;
      void'(stimQ.pop_front());
    end
    @(posedge clk);
    symbol <= '0;
    // the last word trails the last symbol by at most 5 cycles.
    repeat (6) @(posedge clk);
    if (expQ.size() == 0) begin
      passed = 1'b1;
      $display("Everything OK");
      $finish;
    end else begin
      failRun("expected words were left over at the end of the run");
    end
  end

  // outputs are sampled away from the rising edge.
  initial begin
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      if (!started) begin
        compareWord("after reset", '0, packedWord);
      end else if (packedWord.valid) begin
        if (expQ.size() == 0) failRun("the DUT produced a word that was not expected");
        compareWord(nameQ.pop_front(), expQ.pop_front(), packedWord);
      end
    end
  end

  initial begin
    cycles = 0;
    @(posedge rst_n);
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > cycleLimit) failRun("timeout, the DUT did not deliver all expected words");
    end
  end

  // an assertion stop ends the run without the pass path.
  final begin
    if (!passed && !failed) begin
      $display("run ended before all checks completed");
      $display("Something failed");
    end
  end

endmodule

`default_nettype wire

// File: verification/dcEntropyEncoder_asserts.sv
`default_nettype none

module dcEntropyEncoderAsserts
  import jpegStreamPkg::*;
(
  input logic clk,
  input logic rst_n,
  input packedWord_t packedWord
);

  timeunit 1ns;
  timeprecision 1ps;

  // done only rides on a valid word.
  doneHasValid: assert property (@(posedge clk) disable iff (!rst_n)
    packedWord.done |-> packedWord.valid)
    else $error("packer output done is high without valid");

  sizeInRange: assert property (@(posedge clk) disable iff (!rst_n)
    packedWord.valid |-> (packedWord.size >= 1 && packedWord.size <= SIZE_W'(WORD_W)))
    else $error("packer output size %0d is out of range", packedWord.size);

  // words inside a block are always full.
  fullWhenOpen: assert property (@(posedge clk) disable iff (!rst_n)
    (packedWord.valid && !packedWord.done) |-> packedWord.size == SIZE_W'(WORD_W))
    else $error("packer output word without done is not full");

endmodule

`default_nettype wire

// File: verilog.f
design/jpegStreamPkg.sv
design/huffmanCodePkg.sv
design/dcCodeTable.sv
design/codeMerger.sv
design/wordPacker.sv
design/dcEntropyEncoder.sv
verification/dcEntropyEncoder_asserts.sv
verification/dcEntropyEncoderTb.sv
